/* Bender.yml */
package:
  name: proc_sys

sources:
  - include_dirs:
      - include
    files:
      - hdl/ProcSysPkg.sv
      - hdl/BusController.sv
      - hdl/CacheArray.sv
      - hdl/DataMemory.sv
      - hdl/PeripheralRegs.sv
      - hdl/SegmentScanner.sv
      - hdl/ProcessorTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/ProcessorTop_assert.sv
      - testbench/ProcessorTop_tb.sv

/* files.f */
+incdir+include
hdl/ProcSysPkg.sv
hdl/BusController.sv
hdl/CacheArray.sv
hdl/DataMemory.sv
hdl/PeripheralRegs.sv
hdl/SegmentScanner.sv
hdl/ProcessorTop.sv
testbench/ProcessorTop_assert.sv
testbench/ProcessorTop_tb.sv

/* hdl/BusController.sv */
`default_nettype none

module BusController (
    input  logic                 CLK,
    input  logic                 arstN,
    input  ProcSysPkg::wbReqT    wbReq,
    output ProcSysPkg::wbRspT    wbRsp,
    output ProcSysPkg::cacheReqT cacheReq,
    input  logic                 cacheHit,
    input  logic [31:0]          cacheData,
    output ProcSysPkg::memReqT   memReq,
    input  logic                 memReady,
    input  logic [31:0]          memData,
    output ProcSysPkg::ioReqT    ioReq,
    input  logic [31:0]          ioData
);
    import ProcSysPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISSWAIT,
        FILL,
        RESPOND,
        IOACK
    } stateT;

    stateT               state;
    stateT               nextState;
    busAddrT             addr;
    logic [memAddrW-1:0] wordAddr;
    logic                request;
    logic [31:0]         rdData;

    assign addr     = wbReq.adr;
    assign wordAddr = {addr.mem.tag, addr.mem.index};  // High bits dropped so memory wraps
    assign request  = wbReq.cyc & wbReq.stb;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (request) begin
                    nextState = addr.io.region ? IOACK : LOOKUP;
                end
            end
            LOOKUP: begin
                // Stores never allocate, so they finish after the lookup
                nextState = (wbReq.we || cacheHit) ? RESPOND : MISSWAIT;
            end
            MISSWAIT: begin
                if (memReady) begin
                    nextState = FILL;
                end
            end
            FILL: begin
                nextState = RESPOND;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // One holding register serves peripheral, hit and refill data
    always_ff @(posedge CLK) begin
        case (state)
            IDLE: begin
                if (request) begin
                    rdData <= ioData;
                end
            end
            LOOKUP: begin
                rdData <= cacheData;
            end
            MISSWAIT: begin
                if (memReady) begin
                    rdData <= memData;
                end
            end
            default: begin
                rdData <= rdData;
            end
        endcase
    end

    always_comb begin
        cacheReq.lookup = (state == IDLE) && request && !addr.io.region;
        cacheReq.fill   = (state == FILL);
        cacheReq.write  = (state == LOOKUP) && wbReq.we && cacheHit;
        cacheReq.addr   = wordAddr;
        cacheReq.data   = (state == FILL) ? rdData : wbReq.dat;  // Refill takes the memory word
    end

    always_comb begin
        memReq.readValid  = (state == LOOKUP) && !wbReq.we && !cacheHit;
        memReq.writeValid = (state == RESPOND) && wbReq.we;  // Write-through lands with the ack
        memReq.addr       = wordAddr;
        memReq.data       = wbReq.dat;
    end

    always_comb begin
        ioReq.we   = (state == IDLE) && request && addr.io.region && wbReq.we;
        ioReq.sel  = addr.io.sel;
        ioReq.data = wbReq.dat;
    end

    assign wbRsp.ack = request && ((state == RESPOND) || (state == IOACK));
    assign wbRsp.dat = rdData;

endmodule

`default_nettype wire

/* hdl/CacheArray.sv */
`default_nettype none

`include "procSys_macros.svh"

module CacheArray (
    input  logic                 CLK,
    input  logic                 arstN,
    input  ProcSysPkg::cacheReqT cacheReq,
    output logic                 hit,
    output logic [31:0]          readData
);
    import ProcSysPkg::*;

    logic [tagW-1:0]          tagMem  [`CACHE_LINES];
    logic [31:0]              dataMem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]  valid;
    logic [cacheIdxW-1:0]     index;
    logic [tagW-1:0]          tag;
    logic                     tagMatch;

    assign index    = cacheReq.addr[cacheIdxW-1:0];
    assign tag      = cacheReq.addr[memAddrW-1:cacheIdxW];
    assign tagMatch = valid[index] && (tagMem[index] == tag);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            valid <= '0;
            hit   <= 1'b0;
        end else begin
            if (cacheReq.fill) begin
                valid[index] <= 1'b1;
            end
            if (cacheReq.lookup) begin
                hit <= tagMatch;  // Seen by the controller one cycle later
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cacheReq.fill) begin
            tagMem[index]  <= tag;
            dataMem[index] <= cacheReq.data;
        end else if (cacheReq.write && tagMatch) begin
            dataMem[index] <= cacheReq.data;  // Keep a resident line coherent with memory
        end
        if (cacheReq.lookup) begin
            readData <= dataMem[index];
        end
    end

endmodule

`default_nettype wire

/* hdl/DataMemory.sv */
`default_nettype none

`include "procSys_macros.svh"

module DataMemory (
    input  logic               CLK,
    input  ProcSysPkg::memReqT memReq,
    output logic               readReady,
    output logic [31:0]        readData,
    input  logic               arstN
);
    logic [31:0]             mem       [`MEM_WORDS];
    logic [`MEM_LATENCY-1:0] readyPipe;
    logic [31:0]             dataPipe  [`MEM_LATENCY];

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (memReq.writeValid) begin
            mem[memReq.addr] <= memReq.data;
        end
        dataPipe[0] <= mem[memReq.addr];
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    // Ready flag travels beside the data so it arrives on the last stage
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            readyPipe <= '0;
        end else begin
            readyPipe[0] <= memReq.readValid;
            for (int i = 1; i < `MEM_LATENCY; i++) begin
                readyPipe[i] <= readyPipe[i-1];
            end
        end
    end

    assign readReady = readyPipe[`MEM_LATENCY-1];
    assign readData  = dataPipe[`MEM_LATENCY-1];

endmodule

`default_nettype wire

/* hdl/PeripheralRegs.sv */
`default_nettype none

module PeripheralRegs (
    input  logic              CLK,
    input  logic              arstN,
    input  ProcSysPkg::ioReqT ioReq,
    input  logic [15:0]       SW,
    output logic [31:0]       readData,
    output logic [15:0]       LED,
    output logic [31:0]       segValue
);
    import ProcSysPkg::*;

    logic [15:0] ledReg;
    logic [31:0] segReg;
    logic [15:0] swMeta;
    logic [15:0] swSync;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            ledReg <= '0;
            segReg <= '0;
        end else if (ioReq.we) begin
            case (ioReq.sel)
                ioLed: begin
                    ledReg <= ioReq.data[15:0];
                end
                ioSegment: begin
                    segReg <= ioReq.data;
                end
                default: begin
                    ledReg <= ledReg;  // Switches and the spare select are read-only
                end
            endcase
        end
    end

    // Board switches are asynchronous to CLK
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            swMeta <= '0;
            swSync <= '0;
        end else begin
            swMeta <= SW;
            swSync <= swMeta;
        end
    end

    always_comb begin
        case (ioReq.sel)
            ioLed:     readData = {16'h0000, ledReg};
            ioSwitch:  readData = {16'h0000, swSync};
            ioSegment: readData = segReg;
            default:   readData = '0;
        endcase
    end

    assign LED      = ledReg;
    assign segValue = segReg;

endmodule

`default_nettype wire

/* hdl/ProcSysPkg.sv */
`default_nettype none

`include "procSys_macros.svh"

package ProcSysPkg;

    localparam int memAddrW  = $clog2(`MEM_WORDS);
    localparam int cacheIdxW = $clog2(`CACHE_LINES);
    localparam int tagW      = memAddrW - cacheIdxW;
    localparam int addrHighW = 30 - memAddrW;  // Bits above the word address, ignored

    typedef enum logic [1:0] {
        ioLed     = 2'd0,
        ioSwitch  = 2'd1,
        ioSegment = 2'd2
    } ioRegT;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [31:0]          adr;
        logic [31:0]          dat;
    } wbReqT;

    typedef struct packed {
        logic                 ack;
        logic [31:0]          dat;
    } wbRspT;

    typedef struct packed {
        logic [addrHighW-1:0] high;
        logic [tagW-1:0]      tag;
        logic [cacheIdxW-1:0] index;
        logic [1:0]           offset;
    } memAddrT;

    typedef struct packed {
        logic                 region;  // Set for the peripheral space
        logic [26:0]          unused;
        ioRegT                sel;
        logic [1:0]           byteOff;
    } ioAddrT;

    // The same bus word seen by the cache path or by the peripheral path
    typedef union packed {
        memAddrT              mem;
        ioAddrT               io;
    } busAddrT;

    typedef struct packed {
        logic                 readValid;
        logic                 writeValid;
        logic [memAddrW-1:0]  addr;
        logic [31:0]          data;
    } memReqT;

    typedef struct packed {
        logic                 lookup;
        logic                 fill;
        logic                 write;
        logic [memAddrW-1:0]  addr;
        logic [31:0]          data;
    } cacheReqT;

    typedef struct packed {
        logic                 we;
        ioRegT                sel;
        logic [31:0]          data;
    } ioReqT;

endpackage

`default_nettype wire

/* hdl/ProcessorTop.sv */
`default_nettype none

module ProcessorTop (
    input  logic              CLK,
    input  logic              arstN,
    input  ProcSysPkg::wbReqT wbReq,
    output ProcSysPkg::wbRspT wbRsp,
    input  logic [15:0]       SW,
    output logic [15:0]       LED,
    output logic [7:0]        SevenSegAn,
    output logic [6:0]        SevenSegCat
);
    import ProcSysPkg::*;

    cacheReqT    cacheReq;
    logic        cacheHit;
    logic [31:0] cacheData;
    memReqT      memReq;
    logic        memReady;
    logic [31:0] memData;
    ioReqT       ioReq;
    logic [31:0] ioData;
    logic [31:0] segValue;

    BusController u_BusController (
        .CLK       (CLK      ),
        .arstN     (arstN    ),
        .wbReq     (wbReq    ),
        .wbRsp     (wbRsp    ),
        .cacheReq  (cacheReq ),
        .cacheHit  (cacheHit ),
        .cacheData (cacheData),
        .memReq    (memReq   ),
        .memReady  (memReady ),
        .memData   (memData  ),
        .ioReq     (ioReq    ),
        .ioData    (ioData   )
    );

    CacheArray u_CacheArray (
        .CLK      (CLK      ),
        .arstN    (arstN    ),
        .cacheReq (cacheReq ),
        .hit      (cacheHit ),
        .readData (cacheData)
    );

    DataMemory u_DataMemory (
        .CLK       (CLK     ),
        .memReq    (memReq  ),
        .readReady (memReady),
        .readData  (memData ),
        .arstN     (arstN   )
    );

    PeripheralRegs u_PeripheralRegs (
        .CLK      (CLK     ),
        .arstN    (arstN   ),
        .ioReq    (ioReq   ),
        .SW       (SW      ),
        .readData (ioData  ),
        .LED      (LED     ),
        .segValue (segValue)
    );

    SegmentScanner u_SegmentScanner (
        .CLK         (CLK        ),
        .arstN       (arstN      ),
        .segValue    (segValue   ),
        .SevenSegAn  (SevenSegAn ),
        .SevenSegCat (SevenSegCat)
    );

endmodule

`default_nettype wire

/* hdl/SegmentScanner.sv */
`default_nettype none

`include "procSys_macros.svh"

module SegmentScanner (
    input  logic        CLK,
    input  logic        arstN,
    input  logic [31:0] segValue,
    output logic [7:0]  SevenSegAn,
    output logic [6:0]  SevenSegCat
);
    localparam int divW = (`SEG_DIV > 1) ? $clog2(`SEG_DIV) : 1;

    logic [divW-1:0] divCnt;
    logic [2:0]      digit;
    logic [3:0]      nibble;
    logic [6:0]      segOn;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            divCnt <= '0;
            digit  <= '0;
        end else if (divCnt == divW'(`SEG_DIV - 1)) begin
            divCnt <= '0;
            digit  <= digit + 3'd1;  // Wraps from digit 7 back to 0
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    assign nibble = segValue[digit*4 +: 4];

    // Active-high pattern, segment g in bit 6 down to segment a in bit 0
    always_comb begin
        case (nibble)
            4'h0: segOn = 7'h3F;
            4'h1: segOn = 7'h06;
            4'h2: segOn = 7'h5B;
            4'h3: segOn = 7'h4F;
            4'h4: segOn = 7'h66;
            4'h5: segOn = 7'h6D;
            4'h6: segOn = 7'h7D;
            4'h7: segOn = 7'h07;
            4'h8: segOn = 7'h7F;
            4'h9: segOn = 7'h6F;
            4'hA: segOn = 7'h77;
            4'hB: segOn = 7'h7C;
            4'hC: segOn = 7'h39;
            4'hD: segOn = 7'h5E;
            4'hE: segOn = 7'h79;
            default: segOn = 7'h71;
        endcase
    end

    assign SevenSegCat = ~segOn;
    assign SevenSegAn  = ~(8'b0000_0001 << digit);  // Only the selected anode is pulled low

endmodule

`default_nettype wire

/* include/procSys_macros.svh */
`ifndef PROCSYS_MACROS_SVH
`define PROCSYS_MACROS_SVH

// Data memory depth in 32-bit words
`define MEM_WORDS 1024

// Direct-mapped cache with one word per line
`define CACHE_LINES 16

// Cycles from a memory read request to its ready pulse
`define MEM_LATENCY 3

// Clocks spent on each display digit, kept short so simulation sees the scan
`define SEG_DIV 4

`endif

/* testbench/ProcessorTop_assert.sv */
`default_nettype none

module ProcessorTop_assert (
    input logic              CLK,
    input logic              arstN,
    input ProcSysPkg::wbReqT wbReq,
    input ProcSysPkg::wbRspT wbRsp,
    input logic [7:0]        SevenSegAn
);
    int failCount = 0;

    // The request must already have been up for a cycle when ack answers it
    ackNeedsRequest: assert property (@(posedge CLK) disable iff (!arstN)
        wbRsp.ack |-> (wbReq.cyc && wbReq.stb && $past(wbReq.cyc && wbReq.stb)))
        else begin
            $error("ack raised without cyc and stb held from the cycle before");
            failCount++;
        end

    // Classic cycles get exactly one ack each
    ackSinglePulse: assert property (@(posedge CLK) disable iff (!arstN)
        wbRsp.ack |=> !wbRsp.ack)
        else begin
            $error("ack held high for two cycles");
            failCount++;
        end

    oneAnodeLow: assert property (@(posedge CLK) disable iff (!arstN)
        ($countones(~SevenSegAn) == 1) &&
        ((SevenSegAn == $past(SevenSegAn)) ||
         (SevenSegAn == {$past(SevenSegAn[6:0]), $past(SevenSegAn[7])})))  // Next digit or same
        else begin
            $error("anode pattern %b is not one digit on in scan order", SevenSegAn);
            failCount++;
        end

endmodule

bind ProcessorTop ProcessorTop_assert u_ProcessorTop_assert (
    .CLK        (CLK       ),
    .arstN      (arstN     ),
    .wbReq      (wbReq     ),
    .wbRsp      (wbRsp     ),
    .SevenSegAn (SevenSegAn)
);

`default_nettype wire

/* testbench/ProcessorTop_tb.sv */
`default_nettype none

`include "procSys_macros.svh"

module ProcessorTop_tb;
    import ProcSysPkg::*;

    localparam int accessBudget = 200;
    localparam int cycleLimit   = accessBudget * (`MEM_LATENCY + 6) + 2000;
    localparam int ackLimit     = `MEM_LATENCY + 8;  // Longest access is a refill

    logic        CLK;
    logic        arstN;
    wbReqT       wbReq;
    wbRspT       wbRsp;
    logic [15:0] SW;
    logic [15:0] LED;
    logic [7:0]  SevenSegAn;
    logic [6:0]  SevenSegCat;

    logic [31:0] model [`MEM_WORDS];
    logic [15:0] ledModel;
    logic [31:0] segModel;
    int          errors;
    int          assertFails;
    int          cycleCount;

    ProcessorTop u_ProcessorTop (
        .CLK         (CLK        ),
        .arstN       (arstN      ),
        .wbReq       (wbReq      ),
        .wbRsp       (wbRsp      ),
        .SW          (SW         ),
        .LED         (LED        ),
        .SevenSegAn  (SevenSegAn ),
        .SevenSegCat (SevenSegCat)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #50 CLK = ~CLK;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge CLK);
            cycleCount++;
        end
        $display("timeout: run still going after %0d cycles", cycleLimit);
        $display("sim failed");
        $finish;
    end

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the idle cycle
    task automatic busAccess(input logic isWrite, input logic [31:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited    = 0;
        rdat      = 'x;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = isWrite;
        wbReq.adr = adr;
        wbReq.dat = wdat;
        do begin
            @(negedge CLK);
            waited++;
        end while (!wbRsp.ack && waited < ackLimit);
        if (wbRsp.ack) begin
            rdat = wbRsp.dat;
        end else begin
            errors++;
            $display("missing ack for %s at address %h", isWrite ? "write" : "read", adr);
        end
        @(negedge CLK);  // Request stays up through the edge that ends the cycle
        wbReq.cyc = 1'b0;
        wbReq.stb = 1'b0;
        wbReq.we  = 1'b0;
        @(negedge CLK);
    endtask

    task automatic busWrite(input logic [31:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        busAccess(1'b1, adr, data, ignored);
    endtask

    task automatic busRead(input logic [31:0] adr, output logic [31:0] data);
        busAccess(1'b0, adr, 32'h0, data);
    endtask

    // Random upper bits check that memory wraps on the word address
    function automatic logic [31:0] memAddress(input logic [9:0] word);
        return {1'b0, 19'($urandom), word, 2'b00};
    endfunction

    function automatic logic [31:0] ioAddress(input logic [1:0] sel);
        return {1'b1, 27'($urandom), sel, 2'b00};
    endfunction

    task automatic memWrite(input logic [9:0] word, input logic [31:0] data);
        busWrite(memAddress(word), data);
        model[word] = data;
    endtask

    task automatic memCheck(input logic [9:0] word);
        logic [31:0] got;
        busRead(memAddress(word), got);
        compareValue($sformatf("read data at word %0d", word), model[word], got);
    endtask

    // Active-low cathodes, segment a in bit 0
    function automatic logic [6:0] segPattern(input logic [3:0] value);
        case (value)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    initial begin
        logic [9:0]  pool [64];
        logic [31:0] data;
        logic [9:0]  wordA;
        logic [9:0]  wordB;
        logic [3:0]  idx;
        logic [5:0]  tagA;
        logic [5:0]  tagB;
        logic [7:0]  seen;
        int          pick;
        void'($urandom(20514));
        errors   = 0;
        arstN    = 1'b0;
        SW       = '0;
        wbReq    = '0;
        ledModel = '0;
        segModel = '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (2) @(negedge CLK);
        compareValue("SevenSegAn", 32'hFE, {24'h0, SevenSegAn});  // Digit 0 while in reset
        arstN = 1'b1;
        @(negedge CLK);

        compareValue("wbRsp.ack", 32'h0, {31'h0, wbRsp.ack});
        compareValue("LED", 32'h0, {16'h0, LED});
        busRead(memAddress(10'($urandom)), data);
        compareValue("read of unwritten word", 32'h0, data);

        for (int i = 0; i < 64; i++) begin
            pool[i] = 10'($urandom);
        end
        for (int op = 0; op < 70; op++) begin
            pick = $urandom % 64;
            if ($urandom % 2) begin
                memWrite(pool[pick], $urandom);
            end else begin
                memCheck(pool[pick]);
                memCheck(pool[pick]);  // Second read hits the line
            end
        end

        for (int pair = 0; pair < 3; pair++) begin
            idx   = 4'($urandom);
            tagA  = 6'($urandom);
            tagB  = tagA ^ 6'(1 + $urandom % 63);
            wordA = {tagA, idx};
            wordB = {tagB, idx};
            memWrite(wordA, $urandom);
            memCheck(wordA);
            memWrite(wordA, $urandom);  // Store into a resident line
            memCheck(wordA);
            memWrite(wordB, $urandom);
            memCheck(wordB);
            memCheck(wordA);  // A was evicted by B and reloads
        end

        repeat (6) begin
            data = $urandom;
            busWrite(ioAddress(2'd0), data);
            ledModel = data[15:0];
            compareValue("LED", {16'h0, ledModel}, {16'h0, LED});
            busRead(ioAddress(2'd0), data);
            compareValue("LED register read", {16'h0, ledModel}, data);
        end
        busWrite(ioAddress(2'd1), $urandom);
        busWrite(ioAddress(2'd3), $urandom);
        compareValue("LED", {16'h0, ledModel}, {16'h0, LED});
        busRead(ioAddress(2'd0), data);
        compareValue("LED register read", {16'h0, ledModel}, data);
        busRead(ioAddress(2'd3), data);
        compareValue("spare select read", 32'h0, data);
        busRead(ioAddress(2'd2), data);
        compareValue("segment register read", segModel, data);

        repeat (3) begin
            SW = 16'($urandom);
            repeat (3) @(negedge CLK);
            busRead(ioAddress(2'd1), data);
            compareValue("switch read", {16'h0, SW}, data);
        end

        segModel = $urandom;
        busWrite(ioAddress(2'd2), segModel);
        busRead(ioAddress(2'd2), data);
        compareValue("segment register read", segModel, data);
        seen = '0;
        repeat (64 * `SEG_DIV) begin
            @(negedge CLK);
            for (int k = 0; k < 8; k++) begin
                if (!SevenSegAn[k]) begin
                    seen[k] = 1'b1;
                    compareValue($sformatf("SevenSegCat digit %0d", k),
                                 {25'h0, segPattern(segModel[k*4 +: 4])}, {25'h0, SevenSegCat});
                end
            end
        end
        if (seen != 8'hFF) begin
            errors++;
            $display("display never selected every digit, selected mask %b", seen);
        end

        assertFails = u_ProcessorTop.u_ProcessorTop_assert.failCount;
        $display("errors: %0d from checks, %0d from assertions", errors, assertFails);
        if (errors + assertFails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
